/* Bender.yml */
package:
  name: vec_unit

sources:
  # synthesizable sources in compile order
  - target: any(rtl, test)
    files:
      - verilog/vec_pkg.sv
      - verilog/vec_iter_fsm.sv
      - verilog/vec_iter_counter.sv
      - verilog/vec_addr_gen.sv
      - verilog/vec_regfile.sv
      - verilog/vec_mac_lane.sv
      - verilog/vec_unit_top.sv

  # self-checking testbench
  - target: test
    files:
      - test/tb_vec_unit.sv

/* all.f */
verilog/vec_pkg.sv
verilog/vec_iter_fsm.sv
verilog/vec_iter_counter.sv
verilog/vec_addr_gen.sv
verilog/vec_regfile.sv
verilog/vec_mac_lane.sv
verilog/vec_unit_top.sv
test/tb_vec_unit.sv

/* test/tb_vec_unit.sv */
`timescale 1ns/1ps

module tb_vec_unit import vec_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        start;
    vec_op_t     op;
    logic [6:0]  itr;
    logic [5:0]  rf_rd_base;
    logic [5:0]  rf_wr_base;
    logic [31:0] scalar;
    logic        stall;
    logic [31:0] mem_rdata;
    logic [31:0] mem_raddr;
    logic        mem_ren;
    logic [31:0] mem_waddr;
    logic [31:0] mem_wdata;
    logic        mem_wen;
    logic        busy;
    logic        done;

    // memory model, 1k words, and the reference element array
    logic [31:0] mem_model [1024];
    logic [31:0] rf_model [64];

    // expected memory traffic in issue order
    logic [31:0] exp_raddr_q [$];
    logic [31:0] exp_waddr_q [$];
    logic [31:0] exp_wdata_q [$];

    logic [31:0] lfsr;

    vec_unit_top UUT (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .itr        (itr),
        .rf_rd_base (rf_rd_base),
        .rf_wr_base (rf_wr_base),
        .scalar     (scalar),
        .stall      (stall),
        .mem_rdata  (mem_rdata),
        .mem_raddr  (mem_raddr),
        .mem_ren    (mem_ren),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wen    (mem_wen),
        .busy       (busy),
        .done       (done)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic bit rand_bit();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // memory answers a read one cycle later and takes stores at the edge
    always @(posedge clk) begin
        if (!rst) begin
            if (stall && (mem_ren || mem_wen)) begin
                abort_run("memory strobe seen on a stalled cycle");
            end
            if (mem_ren) begin
                if (exp_raddr_q.size() == 0) begin
                    abort_run("memory read that no load asked for");
                end else begin
                    check_equal(mem_raddr, exp_raddr_q.pop_front(), "load address");
                    mem_rdata <= mem_model[mem_raddr[9:0]];
                end
            end
            if (mem_wen) begin
                if (exp_waddr_q.size() == 0) begin
                    abort_run("memory write that no store asked for");
                end else begin
                    check_equal(mem_waddr, exp_waddr_q.pop_front(), "store address");
                    check_equal(mem_wdata, exp_wdata_q.pop_front(), "store data");
                    mem_model[mem_waddr[9:0]] <= mem_wdata;
                end
            end
        end
    end

    // one command from start to idle, then the model catches up
    task automatic run_cmd(input vec_op_t cmd, input int count, input logic [5:0] rd_b,
                           input logic [5:0] wr_b, input logic [31:0] s,
                           input bit use_stall);
        int          cyc;
        int          stalls;
        bit          seen;
        logic [5:0]  w;
        for (int i = 0; i < count; i++) begin
            if (cmd == op_vse32) begin
                exp_waddr_q.push_back(s + 32'(i));
                exp_wdata_q.push_back(rf_model[6'(rd_b + 6'(i))]);
            end
            if (cmd == op_vle32) begin
                exp_raddr_q.push_back(s + 32'(i));
            end
        end
        @(posedge clk);
        start      <= 1'b1;
        op         <= cmd;
        itr        <= 7'(count);
        rf_rd_base <= rd_b;
        rf_wr_base <= wr_b;
        scalar     <= s;
        stall      <= 1'b0;
        @(posedge clk);
        // start taken here, cycles count from this edge
        start <= 1'b0;
        stall <= use_stall ? rand_bit() : 1'b0;
        cyc    = 0;
        stalls = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            cyc++;
            check_equal(32'(busy), 32'd1, "busy while counting");
            if (done) begin
                seen = 1'b1;
            end else begin
                if (stall) begin
                    stalls++;
                end
                if (cyc > 1000) begin
                    abort_run("timeout: done never arrived");
                end
                stall <= use_stall ? rand_bit() : 1'b0;
            end
        end
        stall <= 1'b0;
        check_equal(32'(cyc), 32'(count + stalls), "cycles from start to done");
        @(posedge clk);
        // idle again one cycle after done
        check_equal(32'(busy), 32'd0, "busy after done");
        check_equal(32'(done), 32'd0, "done length");
        check_equal(32'(exp_raddr_q.size()), 32'd0, "loads left over");
        check_equal(32'(exp_waddr_q.size()), 32'd0, "stores left over");
        // element rules in issue order, so overlapping windows see earlier results
        for (int i = 0; i < count; i++) begin
            w = 6'(wr_b + 6'(i));
            if (cmd == op_vle32) begin
                rf_model[w] = mem_model[10'(s + 32'(i))];
            end
            if (cmd == op_vmacc) begin
                rf_model[w] = rf_model[w] + rf_model[6'(rd_b + 6'(i))] * s;
            end
        end
    endtask

    initial begin
        int          n;
        logic [5:0]  rb;
        logic [5:0]  wb;
        logic [5:0]  off;
        lfsr       = 32'h76cd;
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        op         = op_vle32;
        itr        = '0;
        rf_rd_base = '0;
        rf_wr_base = '0;
        scalar     = '0;
        stall      = 1'b0;
        mem_rdata  = '0;
        for (int e = 0; e < 64; e++) begin
            rf_model[e] = '0;
        end
        for (int a = 0; a < 1024; a++) begin
            mem_model[a] = rand_bits(32);
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_equal(32'(busy), 32'd0, "busy after reset");
        check_equal(32'(done), 32'd0, "done after reset");
        check_equal(32'(mem_ren), 32'd0, "mem_ren after reset");
        check_equal(32'(mem_wen), 32'd0, "mem_wen after reset");

        // untouched elements, full file of 64
        run_cmd(op_vse32, 64, 6'd0, 6'd0, 32'd512, 1'b0);

        // shortest command
        run_cmd(op_vle32, 1, 6'd0, 6'd5, 32'd7, 1'b0);
        run_cmd(op_vse32, 1, 6'd5, 6'd0, 32'd900, 1'b0);

        // base 56 with 20 elements runs past 63 and wraps to 0
        run_cmd(op_vle32, 20, 6'd0, 6'd56, 32'd100, 1'b0);
        run_cmd(op_vse32, 20, 6'd56, 6'd0, 32'd700, 1'b1);

        for (int r = 0; r < 16; r++) begin
            n  = 1 + int'(rand_bits(6));
            wb = 6'(rand_bits(6));
            run_cmd(op_vle32, n, 6'd0, wb, rand_bits(9), rand_bit());
            run_cmd(op_vse32, n, wb, 6'd0, rand_bits(9), rand_bit());
            // second block, then mac with destination a few elements above the source
            rb = 6'(rand_bits(6));
            run_cmd(op_vle32, n, 6'd0, rb, rand_bits(9), 1'b0);
            off = 6'(rand_bits(4));
            // one above the source would read an element still in write-back
            if (off == 6'd1) begin
                off = 6'd2;
            end
            wb = rb + off;
            run_cmd(op_vmacc, n, rb, wb, rand_bits(32), rand_bit());
            run_cmd(op_vse32, n, wb, 6'd0, rand_bits(9), rand_bit());
        end

        // mac with the source above the destination
        run_cmd(op_vmacc, 64, 6'd3, 6'd0, rand_bits(32), 1'b1);
        run_cmd(op_vse32, 64, 6'd0, 6'd0, 32'd300, 1'b0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog/vec_addr_gen.sv */
`timescale 1ns/1ps

// per element address generation
// register addresses wrap inside the file, memory addresses are linear
module vec_addr_gen import vec_pkg::*; #(
    parameter int RF_ADDR_W  = rf_addr_w,
    parameter int MEM_ADDR_W = mem_addr_w
) (
    input  vec_op_t               op,
    input  logic                  issue,
    input  logic [RF_ADDR_W-1:0]  idx,
    input  logic [RF_ADDR_W-1:0]  rf_rd_base,
    input  logic [RF_ADDR_W-1:0]  rf_wr_base,
    input  logic [MEM_ADDR_W-1:0] scalar,
    output logic [RF_ADDR_W-1:0]  rf_rd_addr,
    output logic [RF_ADDR_W-1:0]  rf_wr_issue_addr,
    output logic [MEM_ADDR_W-1:0] mem_raddr,
    output logic [MEM_ADDR_W-1:0] mem_waddr,
    output logic                  mem_ren,
    output logic                  mem_wen
);

    logic [MEM_ADDR_W-1:0] mem_addr;

    // carry out of the element add is dropped, so base near the top wraps
    assign rf_rd_addr       = rf_rd_base + idx;
    assign rf_wr_issue_addr = rf_wr_base + idx;

    // scalar holds the word address of element zero
    assign mem_addr = scalar + {{(MEM_ADDR_W - RF_ADDR_W){1'b0}}, idx};

    // loads and stores walk the same word sequence
    assign mem_raddr = mem_addr;
    assign mem_waddr = mem_addr;

    // strobes only on cycles that really issue
    assign mem_ren = issue && (op == op_vle32);
    assign mem_wen = issue && (op == op_vse32);

endmodule

/* verilog/vec_iter_counter.sv */
`timescale 1ns/1ps

// element index counter
// bound is itr - 1, captured on start
module vec_iter_counter import vec_pkg::*; #(
    parameter int RF_ADDR_W = rf_addr_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [RF_ADDR_W:0]   itr,
    input  logic                 issue,
    output logic [RF_ADDR_W-1:0] idx,
    output logic                 last
);

    logic [RF_ADDR_W-1:0] bound_q;

    // itr of 2**RF_ADDR_W still fits once one is taken off
    always_ff @(posedge clk) begin
        if (rst) begin
            bound_q <= '0;
        end else if (start) begin
            bound_q <= RF_ADDR_W'(itr - 1'b1);
        end
    end

    // no issue means stalled or idle, so idx holds
    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (start) begin
            idx <= '0;
        end else if (issue) begin
            if (last) begin
                // back to zero for the next command
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    assign last = (idx == bound_q);

    // an empty command would wrap the bound to the top element
    assert property (@(posedge clk) disable iff (rst) start |-> (itr != '0));

endmodule

/* verilog/vec_iter_fsm.sv */
`timescale 1ns/1ps

// sequencing control
// idle until start, then counting until the last element has issued
module vec_iter_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic stall,
    input  logic last,
    output logic busy,
    output logic issue,
    output logic done
);

    typedef enum logic {
        st_idle  = 1'b0,
        st_count = 1'b1
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // leave counting only after the last element actually went out
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start) begin
                    state_d = st_count;
                end
            end
            st_count: begin
                if (issue && last) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    assign busy = (state_q == st_count);

    // stall holds back one element per cycle
    assign issue = busy && !stall;

    // single pulse on the cycle the last element issues
    assign done = issue && last;

    // a new command must wait for the current one to finish
    assert property (@(posedge clk) disable iff (rst) busy |-> !start);

endmodule

/* verilog/vec_mac_lane.sv */
`timescale 1ns/1ps

// element write-back stage
// one cycle after issue the element is written with load data or the mac result
module vec_mac_lane import vec_pkg::*; #(
    parameter int RF_ADDR_W = rf_addr_w,
    parameter int DATA_W    = data_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  vec_op_t              op,
    input  logic                 issue,
    input  logic [RF_ADDR_W-1:0] wr_addr_in,
    input  logic [DATA_W-1:0]    src,
    input  logic [DATA_W-1:0]    acc,
    input  logic [DATA_W-1:0]    scalar,
    input  logic [DATA_W-1:0]    mem_rdata,
    output logic                 we,
    output logic [RF_ADDR_W-1:0] wa_addr,
    output logic [DATA_W-1:0]    wdata
);

    logic              writes;
    logic              is_load_q;
    logic [DATA_W-1:0] mac_q;

    // stores never touch the register file
    assign writes = issue && (op == op_vle32 || op == op_vmacc);

    always_ff @(posedge clk) begin
        if (rst) begin
            we        <= 1'b0;
            is_load_q <= 1'b0;
        end else begin
            we        <= writes;
            is_load_q <= writes && (op == op_vle32);
        end
    end

    // product is cut to DATA_W bits, upper half is lost
    always_ff @(posedge clk) begin
        if (writes) begin
            wa_addr <= wr_addr_in;
            mac_q   <= acc + src * scalar;
        end
    end

    // memory answers exactly one cycle after the read strobe
    assign wdata = is_load_q ? mem_rdata : mac_q;

endmodule

/* verilog/vec_pkg.sv */
// shared widths and operation codes for the vector element sequencer
package vec_pkg;

    // element address width, 64 elements in the register file
    parameter int rf_addr_w = 6;

    // element and memory word width
    parameter int data_w = 32;

    // external memory word address width
    parameter int mem_addr_w = 32;

    // operation being sequenced
    // vle32 loads words into elements
    // vse32 stores elements to words
    // vmacc adds src * scalar into the destination element
    typedef enum logic [1:0] {
        op_vle32 = 2'd0,
        op_vse32 = 2'd1,
        op_vmacc = 2'd2
    } vec_op_t;

endpackage

/* verilog/vec_regfile.sv */
`timescale 1ns/1ps

// vector element register file
// two async read ports, one clocked write port
module vec_regfile import vec_pkg::*; #(
    parameter int RF_ADDR_W = rf_addr_w,
    parameter int DATA_W    = data_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [RF_ADDR_W-1:0] ra_addr,
    input  logic [RF_ADDR_W-1:0] rb_addr,
    input  logic                 we,
    input  logic [RF_ADDR_W-1:0] wa_addr,
    input  logic [DATA_W-1:0]    wdata,
    output logic [DATA_W-1:0]    ra_data,
    output logic [DATA_W-1:0]    rb_data
);

    localparam int depth = 2 ** RF_ADDR_W;

    logic [DATA_W-1:0] elem [depth];

    // all elements start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                elem[i] <= '0;
            end
        end else if (we) begin
            elem[wa_addr] <= wdata;
        end
    end

    // port a feeds the store data and the mac source
    assign ra_data = elem[ra_addr];

    // port b returns the old destination value for the accumulate
    assign rb_data = elem[rb_addr];

endmodule

/* verilog/vec_unit_top.sv */
`timescale 1ns/1ps

// vector element sequencer top
// control, counter, address generation, register file and write-back lane
module vec_unit_top import vec_pkg::*; #(
    parameter int RF_ADDR_W  = rf_addr_w,
    parameter int DATA_W     = data_w,
    parameter int MEM_ADDR_W = mem_addr_w
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  vec_op_t               op,
    input  logic [RF_ADDR_W:0]    itr,
    input  logic [RF_ADDR_W-1:0]  rf_rd_base,
    input  logic [RF_ADDR_W-1:0]  rf_wr_base,
    input  logic [DATA_W-1:0]     scalar,
    input  logic                  stall,
    input  logic [DATA_W-1:0]     mem_rdata,
    output logic [MEM_ADDR_W-1:0] mem_raddr,
    output logic                  mem_ren,
    output logic [MEM_ADDR_W-1:0] mem_waddr,
    output logic [DATA_W-1:0]     mem_wdata,
    output logic                  mem_wen,
    output logic                  busy,
    output logic                  done
);

    logic                  issue;
    logic                  last;
    logic [RF_ADDR_W-1:0]  idx;
    logic [RF_ADDR_W-1:0]  rf_rd_addr;
    logic [RF_ADDR_W-1:0]  rf_wr_issue_addr;
    logic [MEM_ADDR_W-1:0] mem_base;
    logic [DATA_W-1:0]     ra_data;
    logic [DATA_W-1:0]     rb_data;
    logic                  rf_we;
    logic [RF_ADDR_W-1:0]  rf_wa_addr;
    logic [DATA_W-1:0]     rf_wdata;

    // scalar doubles as the memory base address
    assign mem_base = MEM_ADDR_W'(scalar);

    vec_iter_fsm u_fsm (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .stall (stall),
        .last  (last),
        .busy  (busy),
        .issue (issue),
        .done  (done)
    );

    vec_iter_counter #(
        .RF_ADDR_W (RF_ADDR_W)
    ) u_counter (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .itr   (itr),
        .issue (issue),
        .idx   (idx),
        .last  (last)
    );

    vec_addr_gen #(
        .RF_ADDR_W  (RF_ADDR_W),
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_addr_gen (
        .op               (op),
        .issue            (issue),
        .idx              (idx),
        .rf_rd_base       (rf_rd_base),
        .rf_wr_base       (rf_wr_base),
        .scalar           (mem_base),
        .rf_rd_addr       (rf_rd_addr),
        .rf_wr_issue_addr (rf_wr_issue_addr),
        .mem_raddr        (mem_raddr),
        .mem_waddr        (mem_waddr),
        .mem_ren          (mem_ren),
        .mem_wen          (mem_wen)
    );

    // port b looks at the destination for the accumulate
    vec_regfile #(
        .RF_ADDR_W (RF_ADDR_W),
        .DATA_W    (DATA_W)
    ) u_regfile (
        .clk     (clk),
        .rst     (rst),
        .ra_addr (rf_rd_addr),
        .rb_addr (rf_wr_issue_addr),
        .we      (rf_we),
        .wa_addr (rf_wa_addr),
        .wdata   (rf_wdata),
        .ra_data (ra_data),
        .rb_data (rb_data)
    );

    vec_mac_lane #(
        .RF_ADDR_W (RF_ADDR_W),
        .DATA_W    (DATA_W)
    ) u_mac_lane (
        .clk        (clk),
        .rst        (rst),
        .op         (op),
        .issue      (issue),
        .wr_addr_in (rf_wr_issue_addr),
        .src        (ra_data),
        .acc        (rb_data),
        .scalar     (scalar),
        .mem_rdata  (mem_rdata),
        .we         (rf_we),
        .wa_addr    (rf_wa_addr),
        .wdata      (rf_wdata)
    );

    // store data comes straight off read port a in the issue cycle
    assign mem_wdata = ra_data;

endmodule
